/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert -Wno-fatal
TOP       ?= tb_rename_dispatch
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_TEXT := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass message shows up in its output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/dispatch_pkg.sv
hdl/instr_decode.sv
hdl/station_finder.sv
hdl/dispatch_select.sv
hdl/dispatch_route.sv
hdl/rename_dispatch.sv
sim/tb_rename_dispatch.sv

/* hdl/dispatch_pkg.sv */
`default_nettype none

`include "dispatch_settings.svh"

package dispatch_pkg;

    typedef logic [`PHYS_REG_BITS-1:0] phys_reg_t;
    typedef logic [`ROB_NUM_BITS-1:0]  rob_num_t;
    typedef logic [`RS_IDX_BITS-1:0]   station_idx_t;

    // one lane of the fetch bundle as it leaves the instruction queue
    typedef struct packed {
        logic                    valid;
        logic [31:0]             pc;
        rv_isa_pkg::instr_word_t instr;
        logic                    br_taken_pred;
    } pc_instr_t;

    // per-lane decode result
    // unused sources read as x0
    typedef struct packed {
        rv_isa_pkg::arch_reg_t rd;
        rv_isa_pkg::arch_reg_t rs1;
        rv_isa_pkg::arch_reg_t rs2;
        logic                  uses_rs1;
        logic                  uses_rs2;
        logic                  writes_rd;
        logic                  needs_brq;
    } decoded_t;

    // what dispatch_select hands to dispatch_route for one slot
    typedef struct packed {
        logic                   valid;
        logic [`LANE_BITS-1:0]  lane;
        station_idx_t           station;
        phys_reg_t              pd;
        rob_num_t               rob_num;
    } slot_grant_t;

    typedef struct packed {
        logic                    valid;
        logic [31:0]             pc;
        rv_isa_pkg::instr_word_t instr;
        phys_reg_t               ps1;
        phys_reg_t               ps2;
        phys_reg_t               pd;
        rob_num_t                rob_num;
        logic                    br_taken_pred;
    } rs_entry_t;

    // the ROB entry also carries the new rd mapping for the RAT
    typedef struct packed {
        logic                  valid;
        logic                  has_dest;
        rv_isa_pkg::arch_reg_t rd;
        phys_reg_t             pd;
    } rob_entry_t;

    typedef struct packed {
        rob_num_t rob_num;
    } brq_entry_t;

endpackage

`default_nettype wire

/* hdl/dispatch_route.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_settings.svh"

module dispatch_route (
    input  wire dispatch_pkg::pc_instr_t   [`FETCH_WIDTH-1:0]    i_bundle,
    input  wire dispatch_pkg::decoded_t    [`FETCH_WIDTH-1:0]    i_decoded,
    input  wire dispatch_pkg::slot_grant_t [`DISPATCH_WIDTH-1:0] i_grants,
    // [slot][0] answers rs1, [slot][1] answers rs2
    input  wire dispatch_pkg::phys_reg_t   [`DISPATCH_WIDTH-1:0][1:0] i_src_phys,
    output rv_isa_pkg::arch_reg_t          [`DISPATCH_WIDTH-1:0][1:0] o_src_arch,
    output logic [`NUM_RS-1:0]                                   o_rs_write_mask,
    output dispatch_pkg::rs_entry_t        [`NUM_RS-1:0]         o_rs_entries,
    output dispatch_pkg::rob_entry_t       [`DISPATCH_WIDTH-1:0] o_rob_entries,
    output dispatch_pkg::brq_entry_t       [`DISPATCH_WIDTH-1:0] o_brq_entries
);

    always_comb begin
        dispatch_pkg::pc_instr_t   lane;
        dispatch_pkg::decoded_t    dec;
        dispatch_pkg::slot_grant_t grant;
        int                        n_brq;

        o_src_arch      = '0;
        o_rs_write_mask = '0;
        o_rs_entries    = '0;
        o_rob_entries   = '0;
        o_brq_entries   = '0;
        n_brq           = 0;

        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            grant = i_grants[k];
            lane  = i_bundle[grant.lane];
            dec   = i_decoded[grant.lane];
            if (grant.valid) begin
                // RAT lookup for this slot's sources
                o_src_arch[k][0] = dec.rs1;
                o_src_arch[k][1] = dec.rs2;

                // scatter to the station picked for this slot
                o_rs_write_mask[grant.station]             = 1'b1;
                o_rs_entries[grant.station].valid         = 1'b1;
                o_rs_entries[grant.station].pc            = lane.pc;
                o_rs_entries[grant.station].instr         = lane.instr;
                o_rs_entries[grant.station].ps1           = dec.uses_rs1 ? i_src_phys[k][0] : '0;
                o_rs_entries[grant.station].ps2           = dec.uses_rs2 ? i_src_phys[k][1] : '0;
                o_rs_entries[grant.station].pd            = grant.pd;
                o_rs_entries[grant.station].rob_num       = grant.rob_num;
                o_rs_entries[grant.station].br_taken_pred = lane.br_taken_pred;

                // ROB keeps slot order, which is program order
                o_rob_entries[k].valid    = 1'b1;
                o_rob_entries[k].has_dest = dec.writes_rd;
                o_rob_entries[k].rd       = dec.rd;
                o_rob_entries[k].pd       = grant.pd;

                // control flow packs toward entry 0
                if (dec.needs_brq) begin
                    o_brq_entries[n_brq].rob_num = grant.rob_num;
                    n_brq                        = n_brq + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/dispatch_select.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_settings.svh"

module dispatch_select (
    input  wire logic                                        clk,
    input  wire logic                                        i_arst_n,
    input  wire dispatch_pkg::pc_instr_t [`FETCH_WIDTH-1:0]  i_bundle,
    input  wire logic                                        i_queue_empty,
    input  wire logic                                        i_mispredict,
    input  wire dispatch_pkg::decoded_t  [`FETCH_WIDTH-1:0]  i_decoded,
    input  wire dispatch_pkg::station_idx_t [`DISPATCH_WIDTH-1:0] i_free_stations,
    input  wire logic [`SLOT_CNT_BITS-1:0]                   i_free_count,
    input  wire logic [`ROB_CNT_BITS-1:0]                    i_free_robs,
    input  wire logic [`REG_CNT_BITS-1:0]                    i_free_regs,
    // branch queue entries hold ROB numbers, so it is never deeper than the ROB
    input  wire logic [`ROB_CNT_BITS-1:0]                    i_free_brq,
    input  wire dispatch_pkg::phys_reg_t [`DISPATCH_WIDTH-1:0] i_free_regs_list,
    input  wire dispatch_pkg::rob_num_t                      i_next_rob_num,
    output dispatch_pkg::slot_grant_t [`DISPATCH_WIDTH-1:0]  o_grants,
    output logic [`SLOT_CNT_BITS-1:0]                        o_rob_push,
    output logic [`SLOT_CNT_BITS-1:0]                        o_brq_push,
    output logic [`SLOT_CNT_BITS-1:0]                        o_free_list_pop,
    output logic                                             o_queue_pop
);

    // lanes of the current bundle already dispatched
    logic [`FETCH_WIDTH-1:0] sent_q;
    logic [`FETCH_WIDTH-1:0] sent_next;
    logic [`FETCH_WIDTH-1:0] valid_mask;

    always_comb begin
        int   n_slot;
        int   n_reg;
        int   n_brq;
        logic stop;

        n_slot    = 0;
        n_reg     = 0;
        n_brq     = 0;
        sent_next = sent_q;
        o_grants  = '0;
        // nothing goes out on a flush or with no bundle
        stop      = i_queue_empty || i_mispredict;

        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            valid_mask[i] = i_bundle[i].valid;
            if (!stop && i_bundle[i].valid && !sent_q[i]) begin
                // first lane short of any resource blocks every later lane
                if (n_slot >= `DISPATCH_WIDTH || n_slot >= i_free_robs ||
                    n_slot >= i_free_count ||
                    (i_decoded[i].writes_rd && n_reg >= i_free_regs) ||
                    (i_decoded[i].needs_brq && n_brq >= i_free_brq)) begin
                    stop = 1'b1;
                end else begin
                    o_grants[n_slot].valid   = 1'b1;
                    o_grants[n_slot].lane    = `LANE_BITS'(i);
                    o_grants[n_slot].station = i_free_stations[n_slot];
                    o_grants[n_slot].rob_num = i_next_rob_num + `ROB_NUM_BITS'(n_slot);
                    if (i_decoded[i].writes_rd) begin
                        // free-list registers are taken in order
                        o_grants[n_slot].pd = i_free_regs_list[n_reg];
                        n_reg               = n_reg + 1;
                    end
                    if (i_decoded[i].needs_brq) begin
                        n_brq = n_brq + 1;
                    end
                    sent_next[i] = 1'b1;
                    n_slot       = n_slot + 1;
                end
            end
        end

        o_rob_push      = `SLOT_CNT_BITS'(n_slot);
        o_free_list_pop = `SLOT_CNT_BITS'(n_reg);
        o_brq_push      = `SLOT_CNT_BITS'(n_brq);
        // whole bundle gone once every valid lane is sent
        o_queue_pop     = !i_queue_empty && !i_mispredict &&
                          ((sent_next | ~valid_mask) == '1);
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sent_q <= '0;
        end else if (i_mispredict || o_queue_pop) begin
            // next bundle, or the refetched one, starts from lane 0
            sent_q <= '0;
        end else begin
            sent_q <= sent_next;
        end
    end

    a_rob_push_fits: assert property (@(posedge clk) disable iff (!i_arst_n)
        `ROB_CNT_BITS'(o_rob_push) <= i_free_robs);

    // a pop only takes a bundle that is there
    a_pop_needs_bundle: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_queue_pop |-> !i_queue_empty);

endmodule

`default_nettype wire

/* hdl/dispatch_settings.svh */
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// lanes per fetch bundle and dispatch slots per cycle
`define FETCH_WIDTH      4
`define DISPATCH_WIDTH   2

// backing structure sizes
`define NUM_PHYS_REGS    64
`define NUM_ROB_ENTRIES  16
`define NUM_RS           8

// index widths
`define LANE_BITS        ($clog2(`FETCH_WIDTH))
`define PHYS_REG_BITS    ($clog2(`NUM_PHYS_REGS))
`define ROB_NUM_BITS     ($clog2(`NUM_ROB_ENTRIES))
`define RS_IDX_BITS      ($clog2(`NUM_RS))

// count widths, each holds its full count
`define SLOT_CNT_BITS    ($clog2(`DISPATCH_WIDTH + 1))
`define ROB_CNT_BITS     ($clog2(`NUM_ROB_ENTRIES + 1))
`define REG_CNT_BITS     ($clog2(`NUM_PHYS_REGS + 1))

`endif

/* hdl/instr_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_settings.svh"

module instr_decode (
    input  wire dispatch_pkg::pc_instr_t [`FETCH_WIDTH-1:0] i_bundle,
    output dispatch_pkg::decoded_t       [`FETCH_WIDTH-1:0] o_decoded
);

    always_comb begin
        rv_isa_pkg::r_fields_t fields;
        logic                  has_rd;

        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            fields       = i_bundle[i].instr;
            o_decoded[i] = '0;
            has_rd       = 1'b1;

            // source usage by format
            case (rv_isa_pkg::opcode_e'(fields.opcode))
                rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc, rv_isa_pkg::op_jal: begin
                    o_decoded[i].uses_rs1 = 1'b0;
                    o_decoded[i].uses_rs2 = 1'b0;
                end
                rv_isa_pkg::op_jalr, rv_isa_pkg::op_imm: begin
                    o_decoded[i].uses_rs1 = 1'b1;
                    o_decoded[i].uses_rs2 = 1'b0;
                end
                rv_isa_pkg::op_br: begin
                    // B-type keeps immediate bits where rd would be
                    o_decoded[i].uses_rs1 = 1'b1;
                    o_decoded[i].uses_rs2 = 1'b1;
                    has_rd                = 1'b0;
                end
                default: begin
                    // op_reg, and anything unknown is treated the same
                    o_decoded[i].uses_rs1 = 1'b1;
                    o_decoded[i].uses_rs2 = 1'b1;
                end
            endcase

            if (o_decoded[i].uses_rs1) begin
                o_decoded[i].rs1 = fields.rs1;
            end
            if (o_decoded[i].uses_rs2) begin
                o_decoded[i].rs2 = fields.rs2;
            end
            if (has_rd) begin
                o_decoded[i].rd = fields.rd;
            end

            // x0 is never renamed
            o_decoded[i].writes_rd = has_rd && (fields.rd != '0);
            o_decoded[i].needs_brq = fields.opcode inside
                {rv_isa_pkg::op_br, rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr};
        end
    end

endmodule

`default_nettype wire

/* hdl/rename_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_settings.svh"

module rename_dispatch (
    input  wire logic                                           clk,
    input  wire logic                                           i_arst_n,
    // instruction queue
    input  wire dispatch_pkg::pc_instr_t [`FETCH_WIDTH-1:0]     i_bundle,
    input  wire logic                                           i_queue_empty,
    output logic                                                o_queue_pop,
    // resources
    input  wire logic [`ROB_CNT_BITS-1:0]                       i_free_robs,
    input  wire dispatch_pkg::rob_num_t                         i_next_rob_num,
    input  wire logic [`REG_CNT_BITS-1:0]                       i_free_regs,
    input  wire dispatch_pkg::phys_reg_t [`DISPATCH_WIDTH-1:0]  i_free_regs_list,
    input  wire logic [`ROB_CNT_BITS-1:0]                       i_free_brq,
    input  wire logic [`NUM_RS-1:0]                             i_rs_busy_mask,
    input  wire logic                                           i_mispredict,
    // RAT lookup
    output rv_isa_pkg::arch_reg_t [`DISPATCH_WIDTH-1:0][1:0]    o_src_arch,
    input  wire dispatch_pkg::phys_reg_t [`DISPATCH_WIDTH-1:0][1:0] i_src_phys,
    // dispatch writes
    output logic [`NUM_RS-1:0]                                  o_rs_write_mask,
    output dispatch_pkg::rs_entry_t [`NUM_RS-1:0]               o_rs_entries,
    output logic [`SLOT_CNT_BITS-1:0]                           o_rob_push,
    output dispatch_pkg::rob_entry_t [`DISPATCH_WIDTH-1:0]      o_rob_entries,
    output logic [`SLOT_CNT_BITS-1:0]                           o_brq_push,
    output dispatch_pkg::brq_entry_t [`DISPATCH_WIDTH-1:0]      o_brq_entries,
    output logic [`SLOT_CNT_BITS-1:0]                           o_free_list_pop
);

    dispatch_pkg::decoded_t     [`FETCH_WIDTH-1:0]    decoded;
    dispatch_pkg::station_idx_t [`DISPATCH_WIDTH-1:0] free_stations;
    logic [`SLOT_CNT_BITS-1:0]                        free_count;
    dispatch_pkg::slot_grant_t  [`DISPATCH_WIDTH-1:0] grants;

    instr_decode instr_decode_inst (
        .i_bundle  (i_bundle),
        .o_decoded (decoded)
    );

    station_finder station_finder_inst (
        .i_rs_busy_mask  (i_rs_busy_mask),
        .o_free_stations (free_stations),
        .o_free_count    (free_count)
    );

    dispatch_select dispatch_select_inst (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .i_bundle         (i_bundle),
        .i_queue_empty    (i_queue_empty),
        .i_mispredict     (i_mispredict),
        .i_decoded        (decoded),
        .i_free_stations  (free_stations),
        .i_free_count     (free_count),
        .i_free_robs      (i_free_robs),
        .i_free_regs      (i_free_regs),
        .i_free_brq       (i_free_brq),
        .i_free_regs_list (i_free_regs_list),
        .i_next_rob_num   (i_next_rob_num),
        .o_grants         (grants),
        .o_rob_push       (o_rob_push),
        .o_brq_push       (o_brq_push),
        .o_free_list_pop  (o_free_list_pop),
        .o_queue_pop      (o_queue_pop)
    );

    dispatch_route dispatch_route_inst (
        .i_bundle        (i_bundle),
        .i_decoded       (decoded),
        .i_grants        (grants),
        .i_src_phys      (i_src_phys),
        .o_src_arch      (o_src_arch),
        .o_rs_write_mask (o_rs_write_mask),
        .o_rs_entries    (o_rs_entries),
        .o_rob_entries   (o_rob_entries),
        .o_brq_entries   (o_brq_entries)
    );

endmodule

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // base opcodes of RV32I
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    typedef logic [4:0]  arch_reg_t;
    typedef logic [31:0] instr_word_t;

    // register fields sit at the same bits in every format that has them
    typedef struct packed {
        logic [6:0] funct7;
        arch_reg_t  rs2;
        arch_reg_t  rs1;
        logic [2:0] funct3;
        arch_reg_t  rd;
        logic [6:0] opcode;
    } r_fields_t;

endpackage

`default_nettype wire

/* hdl/station_finder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_settings.svh"

module station_finder (
    input  wire logic [`NUM_RS-1:0]                        i_rs_busy_mask,
    output dispatch_pkg::station_idx_t [`DISPATCH_WIDTH-1:0] o_free_stations,
    output logic [`SLOT_CNT_BITS-1:0]                      o_free_count
);

    always_comb begin
        int cnt;
        int free_total;

        cnt             = 0;
        o_free_stations = '0;
        free_total      = $countones(~i_rs_busy_mask);

        // lowest index first, stop listing once every slot has one
        for (int s = 0; s < `NUM_RS; s++) begin
            if (!i_rs_busy_mask[s] && cnt < `DISPATCH_WIDTH) begin
                o_free_stations[cnt] = dispatch_pkg::station_idx_t'(s);
                cnt                  = cnt + 1;
            end
        end
        o_free_count = `SLOT_CNT_BITS'(cnt);

        // the list holds every free station, up to one per slot
        assert (int'(o_free_count) ==
                ((free_total < `DISPATCH_WIDTH) ? free_total : `DISPATCH_WIDTH))
            else $error("station_finder counted %0d of %0d free stations",
                        o_free_count, free_total);

        // a listed station must really be free
        for (int k = 0; k < int'(o_free_count); k++) begin
            assert (!i_rs_busy_mask[o_free_stations[k]])
                else $error("station_finder listed busy station %0d", o_free_stations[k]);
        end
    end

endmodule

`default_nettype wire

/* sim/dispatch_input.txt */
// tag empty mispredict free_robs free_regs free_brq busy next_rob freereg0 freereg1 valid pred pc
// instr0 instr1 instr2 instr3, then expected pop rob_push brq_push free_list_pop rs_write_mask
1 1 0 10 40 10 00 0 20 21 f 0 1000 003100b3 00628233 009403b3 00c58533 0 0 0 0 00
2 0 0 10 40 10 00 0 21 22 f 0 1000 003100b3 00628233 009403b3 00c58533 0 2 0 2 03
3 0 0 10 40 10 05 2 23 24 f 0 1000 003100b3 00628233 009403b3 00c58533 1 2 0 2 0a
4 0 0 10 40 10 00 4 25 26 3 2 2000 003100b3 00628233 009403b3 00c58533 1 2 0 2 03
5 0 0 10 01 10 00 6 27 28 f 0 4000 009403b3 00c58533 00208033 00570693 0 1 0 1 01
6 0 0 10 01 10 00 7 28 29 f 0 4000 009403b3 00c58533 00208033 00570693 0 2 0 1 03
7 0 0 10 00 10 00 9 2a 2b f 0 4000 009403b3 00c58533 00208033 00570693 0 0 0 0 00
8 0 0 10 02 10 00 9 2a 2b f 0 4000 009403b3 00c58533 00208033 00570693 1 1 0 1 01
9 0 0 10 40 00 00 a 2b 2c f 1 3000 01078463 008000ef 123458b7 00008067 0 0 0 0 00
a 0 0 10 40 10 03 a 2b 2c f 1 3000 01078463 008000ef 123458b7 00008067 0 2 2 1 0c
b 0 1 10 40 10 00 c 2c 2d f 1 3000 01078463 008000ef 123458b7 00008067 0 0 0 0 00
c 0 0 10 40 01 00 c 2c 2d f 1 3000 01078463 008000ef 123458b7 00008067 0 1 1 0 01
d 0 0 01 40 10 00 d 2d 2e f 1 3000 01078463 008000ef 123458b7 00008067 0 1 1 1 01
e 0 0 10 40 10 00 e 2e 2f f 1 3000 01078463 008000ef 123458b7 00008067 1 2 1 1 03

/* sim/tb_rename_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_settings.svh"

module tb_rename_dispatch;

    // tag, 16 stimulus columns, 5 expected columns per line
    localparam int NUM_COLS  = 22;
    localparam int MAX_LINES = 64;

    logic                                               clk;
    logic                                               arst_n;
    dispatch_pkg::pc_instr_t  [`FETCH_WIDTH-1:0]        bundle;
    logic                                               queue_empty;
    logic                                               queue_pop;
    logic [`ROB_CNT_BITS-1:0]                           free_robs;
    dispatch_pkg::rob_num_t                             next_rob_num;
    logic [`REG_CNT_BITS-1:0]                           free_regs;
    dispatch_pkg::phys_reg_t  [`DISPATCH_WIDTH-1:0]     free_regs_list;
    logic [`ROB_CNT_BITS-1:0]                           free_brq;
    logic [`NUM_RS-1:0]                                 rs_busy_mask;
    logic                                               mispredict;
    rv_isa_pkg::arch_reg_t    [`DISPATCH_WIDTH-1:0][1:0] src_arch;
    dispatch_pkg::phys_reg_t  [`DISPATCH_WIDTH-1:0][1:0] src_phys;
    logic [`NUM_RS-1:0]                                 rs_write_mask;
    dispatch_pkg::rs_entry_t  [`NUM_RS-1:0]             rs_entries;
    logic [`SLOT_CNT_BITS-1:0]                          rob_push;
    dispatch_pkg::rob_entry_t [`DISPATCH_WIDTH-1:0]     rob_entries;
    logic [`SLOT_CNT_BITS-1:0]                          brq_push;
    dispatch_pkg::brq_entry_t [`DISPATCH_WIDTH-1:0]     brq_entries;
    logic [`SLOT_CNT_BITS-1:0]                          free_list_pop;

    logic [31:0]             stim_mem [0:NUM_COLS*MAX_LINES-1];
    // lanes of the current bundle that the expected counts say are gone
    logic [`FETCH_WIDTH-1:0] sent_model;
    int                      num_lines;
    int                      cycle_count;
    int                      cycle_limit;
    int                      count_errors;
    int                      entry_errors;
    int                      other_errors;

    rename_dispatch rename_dispatch_inst (
        .clk (clk), .i_arst_n (arst_n),
        .i_bundle (bundle), .i_queue_empty (queue_empty), .o_queue_pop (queue_pop),
        .i_free_robs (free_robs), .i_next_rob_num (next_rob_num),
        .i_free_regs (free_regs), .i_free_regs_list (free_regs_list),
        .i_free_brq (free_brq), .i_rs_busy_mask (rs_busy_mask), .i_mispredict (mispredict),
        .o_src_arch (src_arch), .i_src_phys (src_phys),
        .o_rs_write_mask (rs_write_mask), .o_rs_entries (rs_entries),
        .o_rob_push (rob_push), .o_rob_entries (rob_entries),
        .o_brq_push (brq_push), .o_brq_entries (brq_entries),
        .o_free_list_pop (free_list_pop)
    );

    // RAT model, every arch register maps to itself plus 32
    always_comb begin
        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            for (int j = 0; j < 2; j++) begin
                src_phys[k][j] = dispatch_pkg::phys_reg_t'(src_arch[k][j]) + 6'd32;
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run went past %0d clock cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] stim_field(input int n, input int c);
        return stim_mem[n*NUM_COLS + c];
    endfunction

    // register usage by RV32I format
    function automatic dispatch_pkg::decoded_t expected_decode(input rv_isa_pkg::instr_word_t w);
        dispatch_pkg::decoded_t d;
        logic [6:0]             opc;

        opc         = w[6:0];
        d           = '0;
        d.uses_rs1  = !(opc inside {rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc, rv_isa_pkg::op_jal});
        d.uses_rs2  = d.uses_rs1 && !(opc inside {rv_isa_pkg::op_jalr, rv_isa_pkg::op_imm});
        d.needs_brq = opc inside {rv_isa_pkg::op_br, rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr};
        if (d.uses_rs1) begin
            d.rs1 = w[19:15];
        end
        if (d.uses_rs2) begin
            d.rs2 = w[24:20];
        end
        // branches have immediate bits in the rd field
        if (opc != rv_isa_pkg::op_br) begin
            d.rd = w[11:7];
        end
        d.writes_rd = (d.rd != '0);
        return d;
    endfunction

    task automatic check_count(input string what, input logic [`SLOT_CNT_BITS-1:0] got,
                               input logic [`SLOT_CNT_BITS-1:0] exp);
        if (got !== exp) begin
            count_errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_mask(input logic [`NUM_RS-1:0] got, input logic [`NUM_RS-1:0] exp);
        if (got !== exp) begin
            count_errors++;
            $display("MISMATCH at %0t: rs write mask got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_rs_entry(input int s, input dispatch_pkg::rs_entry_t got,
                                  input dispatch_pkg::rs_entry_t exp);
        if (got !== exp) begin
            entry_errors++;
            $display("MISMATCH at %0t: station %0d got %h expected %h", $time, s, got, exp);
        end
    endtask

    task automatic check_rob_entry(input int k, input dispatch_pkg::rob_entry_t got,
                                   input dispatch_pkg::rob_entry_t exp);
        if (got !== exp) begin
            entry_errors++;
            $display("MISMATCH at %0t: rob slot %0d got %h expected %h", $time, k, got, exp);
        end
    endtask

    task automatic check_brq_entry(input int k, input dispatch_pkg::brq_entry_t got,
                                   input dispatch_pkg::brq_entry_t exp);
        if (got !== exp) begin
            entry_errors++;
            $display("MISMATCH at %0t: brq slot %0d got %h expected %h", $time, k, got, exp);
        end
    endtask

    task automatic apply_line(input int n);
        logic [`FETCH_WIDTH-1:0] valid_bits;
        logic [`FETCH_WIDTH-1:0] pred_bits;

        queue_empty       = stim_field(n, 1) != 0;
        mispredict        = stim_field(n, 2) != 0;
        free_robs         = `ROB_CNT_BITS'(stim_field(n, 3));
        free_regs         = `REG_CNT_BITS'(stim_field(n, 4));
        free_brq          = `ROB_CNT_BITS'(stim_field(n, 5));
        rs_busy_mask      = `NUM_RS'(stim_field(n, 6));
        next_rob_num      = dispatch_pkg::rob_num_t'(stim_field(n, 7));
        free_regs_list[0] = dispatch_pkg::phys_reg_t'(stim_field(n, 8));
        free_regs_list[1] = dispatch_pkg::phys_reg_t'(stim_field(n, 9));
        valid_bits        = `FETCH_WIDTH'(stim_field(n, 10));
        pred_bits         = `FETCH_WIDTH'(stim_field(n, 11));
        // lanes sit at consecutive word addresses
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            bundle[i].valid         = valid_bits[i];
            bundle[i].pc            = stim_field(n, 12) + 32'(4*i);
            bundle[i].instr         = stim_field(n, 13 + i);
            bundle[i].br_taken_pred = pred_bits[i];
        end
    endtask

    task automatic check_line(input int n);
        dispatch_pkg::rs_entry_t  [`NUM_RS-1:0]         exp_rs;
        dispatch_pkg::rob_entry_t [`DISPATCH_WIDTH-1:0] exp_rob;
        dispatch_pkg::brq_entry_t [`DISPATCH_WIDTH-1:0] exp_brq;
        dispatch_pkg::decoded_t                         dec;
        dispatch_pkg::station_idx_t                     st;
        dispatch_pkg::phys_reg_t                        pd;
        dispatch_pkg::rob_num_t                         rob_num;
        int                                             lanes[$];
        int                                             free_st[$];
        int                                             exp_push;
        int                                             n_reg;
        int                                             n_brq;

        check_count("queue pop", `SLOT_CNT_BITS'(queue_pop), `SLOT_CNT_BITS'(stim_field(n, 17)));
        check_count("rob push", rob_push, `SLOT_CNT_BITS'(stim_field(n, 18)));
        check_count("brq push", brq_push, `SLOT_CNT_BITS'(stim_field(n, 19)));
        check_count("free list pop", free_list_pop, `SLOT_CNT_BITS'(stim_field(n, 20)));
        check_mask(rs_write_mask, `NUM_RS'(stim_field(n, 21)));

        // the first exp_push unsent valid lanes go out, in lane order
        exp_push = int'(stim_field(n, 18));
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (bundle[i].valid && !sent_model[i]) begin
                lanes.push_back(i);
            end
        end
        // slot k lands in the k-th lowest free station
        for (int s = 0; s < `NUM_RS; s++) begin
            if (!rs_busy_mask[s]) begin
                free_st.push_back(s);
            end
        end
        exp_rs  = '0;
        exp_rob = '0;
        exp_brq = '0;
        n_reg   = 0;
        n_brq   = 0;
        for (int k = 0; k < exp_push && k < lanes.size() && k < free_st.size() &&
             k < `DISPATCH_WIDTH; k++) begin
            dec     = expected_decode(bundle[lanes[k]].instr);
            st      = dispatch_pkg::station_idx_t'(free_st[k]);
            rob_num = next_rob_num + dispatch_pkg::rob_num_t'(k);
            pd      = '0;
            if (dec.writes_rd) begin
                pd = free_regs_list[n_reg];
                n_reg++;
            end
            exp_rs[st].valid         = 1'b1;
            exp_rs[st].pc            = bundle[lanes[k]].pc;
            exp_rs[st].instr         = bundle[lanes[k]].instr;
            exp_rs[st].ps1           = dec.uses_rs1 ? 6'(dec.rs1) + 6'd32 : '0;
            exp_rs[st].ps2           = dec.uses_rs2 ? 6'(dec.rs2) + 6'd32 : '0;
            exp_rs[st].pd            = pd;
            exp_rs[st].rob_num       = rob_num;
            exp_rs[st].br_taken_pred = bundle[lanes[k]].br_taken_pred;
            exp_rob[k]               = '{valid: 1'b1, has_dest: dec.writes_rd, rd: dec.rd, pd: pd};
            if (dec.needs_brq) begin
                exp_brq[n_brq].rob_num = rob_num;
                n_brq++;
            end
            sent_model[lanes[k]] = 1'b1;
        end

        for (int s = 0; s < `NUM_RS; s++) begin
            check_rs_entry(s, rs_entries[s], exp_rs[s]);
        end
        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            check_rob_entry(k, rob_entries[k], exp_rob[k]);
            check_brq_entry(k, brq_entries[k], exp_brq[k]);
        end
        // a pop or a flush starts the next bundle from lane 0
        if (stim_field(n, 17) != 0 || mispredict) begin
            sent_model = '0;
        end
    endtask

    initial begin
        arst_n         = 1'b0;
        bundle         = '0;
        queue_empty    = 1'b1;
        mispredict     = 1'b0;
        free_robs      = '0;
        free_regs      = '0;
        free_brq       = '0;
        rs_busy_mask   = '0;
        next_rob_num   = '0;
        free_regs_list = '0;
        sent_model     = '0;
        cycle_count    = 0;
        count_errors   = 0;
        entry_errors   = 0;
        other_errors   = 0;

        // lines carry tags 1, 2, 3 and so on, the first miss ends the table
        $readmemh("sim/dispatch_input.txt", stim_mem);
        num_lines = 0;
        while (num_lines < MAX_LINES && stim_mem[num_lines*NUM_COLS] == 32'(num_lines + 1)) begin
            num_lines++;
        end
        cycle_limit = num_lines + 20;
        if (num_lines == 0) begin
            $display("no stimulus lines could be read from sim/dispatch_input.txt");
            other_errors++;
        end

        repeat (3) @(posedge clk);
        #10 arst_n = 1'b1;

        // drive just after the edge, check just before the next one
        for (int n = 0; n < num_lines; n++) begin
            @(posedge clk);
            #10;
            apply_line(n);
            #80;
            check_line(n);
        end

        $display("%0d lines run: %0d count errors, %0d entry errors, %0d other errors",
                 num_lines, count_errors, entry_errors, other_errors);
        if (count_errors + entry_errors + other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
